//--- src/ld_pkg.sv
package ld_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and memory map
	//////////////////////////////////////////////////////////////////////

	// 32 words of scratch
	localparam int MEM_AW = 5;

	// Autocorrelation input area
	localparam logic [MEM_AW-1:0] R_BASE = 5'd0;
	// Result area, one word per coefficient index
	localparam logic [MEM_AW-1:0] RES_BASE = 5'd16;

	// Q15 for R and rc, Q12 for a
	typedef logic signed [15:0] sample_t;
	// Prediction error, Q15
	typedef logic signed [31:0] energy_t;
	// Wide accumulator for products
	typedef logic signed [47:0] acc_t;

	//////////////////////////////////////////////////////////////////////
	// Scratch word views
	//////////////////////////////////////////////////////////////////////

	// Result layout
	typedef struct packed {
		sample_t coef;
		sample_t rc;
	} result_t;

	// Input view holds a sign-extended R value
	typedef union packed {
		logic signed [31:0] r;
		result_t res;
	} scratch_word_t;

	// One MAC term
	typedef struct packed {
		logic first;
		logic last;
		sample_t coef;
		sample_t corr;
	} mac_term_t;

	// Clip a wide value to the 16-bit range
	function automatic sample_t sat16(input acc_t v);
		if (v > acc_t'(32767))
			return sample_t'(16'sh7fff);
		else if (v < acc_t'(-32768))
			return sample_t'(16'sh8000);
		return sample_t'(v);
	endfunction

endpackage

//--- src/ld_scratch_mem.sv
`timescale 1ns/10ps

module ld_scratch_mem (
	input logic clock,
	input logic rst,
	input logic busy,
	input logic test_we,
	input logic [ld_pkg::MEM_AW-1:0] test_addr,
	input ld_pkg::scratch_word_t test_wdata,
	input logic eng_we,
	input logic [ld_pkg::MEM_AW-1:0] eng_addr,
	input ld_pkg::scratch_word_t eng_wdata,
	output ld_pkg::scratch_word_t rdata
);
	import ld_pkg::*;

	// Storage array
	scratch_word_t mem [0:(1<<MEM_AW)-1];

	// Selected port
	logic we;
	logic [MEM_AW-1:0] addr;
	scratch_word_t wdata;

	//////////////////////////////////////////////////////////////////////
	// Port arbiter
	//////////////////////////////////////////////////////////////////////

	// Engine owns the array while busy
	always_comb
	begin
		if (busy)
		begin
			we = eng_we;
			addr = eng_addr;
			wdata = eng_wdata;
		end
		else
		begin
			// Idle, test port has it
			we = test_we;
			addr = test_addr;
			wdata = test_wdata;
		end
	end

	// Write on the sampling edge
	always_ff @(posedge clock)
	begin
		if (we)
			mem[addr] <= wdata;
	end

	// Registered read, shared by both ports
	always_ff @(posedge clock)
	begin
		if (rst)
			rdata <= '0;
		else
			rdata <= mem[addr];
	end

endmodule

//--- src/ld_mac.sv
`timescale 1ns/10ps

module ld_mac (
	input logic clock,
	input logic rst,
	input logic term_valid,
	input ld_pkg::mac_term_t term,
	output logic num_valid,
	output ld_pkg::sample_t num
);
	import ld_pkg::*;

	// Running sum, Q27
	acc_t acc;

	// Current product and sum
	acc_t prod;
	acc_t sum;
	// Back to Q15
	acc_t scaled;

	always_comb
	begin
		prod = acc_t'(term.coef) * acc_t'(term.corr);
		// First term seeds the sum
		if (term.first)
			sum = prod;
		else
			sum = acc + prod;
		scaled = sum >>> 12;
	end

	//////////////////////////////////////////////////////////////////////
	// Accumulator and strobe
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			acc <= '0;
			num_valid <= 1'b0;
		end
		else
		begin
			num_valid <= term_valid && term.last;
			if (term_valid)
				acc <= sum;
		end
	end

	// Numerator held until the next closing term
	always_ff @(posedge clock)
	begin
		if (term_valid && term.last)
			num <= sat16(scaled);
	end

endmodule

//--- src/ld_energy.sv
`timescale 1ns/10ps

module ld_energy (
	input logic clock,
	input logic rst,
	input logic init,
	input logic update,
	input ld_pkg::sample_t r0,
	input ld_pkg::sample_t k,
	output ld_pkg::energy_t energy
);
	import ld_pkg::*;

	// k squared, Q15
	acc_t k_sq;
	// Error removed by this step
	acc_t loss;
	// Unclamped next values
	acc_t next_upd;
	acc_t next_init;

	always_comb
	begin
		k_sq = (acc_t'(k) * acc_t'(k)) >>> 15;
		loss = (k_sq * acc_t'(energy)) >>> 15;
		next_upd = acc_t'(energy) - loss;
		next_init = acc_t'(r0);
	end

	//////////////////////////////////////////////////////////////////////
	// Error register, floor of 1
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
			energy <= 32'sd1;
		else if (init)
		begin
			// New frame starts from R[0]
			if (next_init < acc_t'(1))
				energy <= 32'sd1;
			else
				energy <= energy_t'(next_init);
		end
		else if (update)
		begin
			if (next_upd < acc_t'(1))
				energy <= 32'sd1;
			else
				energy <= energy_t'(next_upd);
		end
	end

endmodule

//--- src/ld_divider.sv
`timescale 1ns/10ps

module ld_divider (
	input logic clock,
	input logic rst,
	input logic div_start,
	input ld_pkg::sample_t num,
	input ld_pkg::energy_t den,
	output logic div_done,
	output ld_pkg::sample_t k
);
	import ld_pkg::*;

	// Operand magnitudes
	logic [47:0] num_mag;
	logic [47:0] den_mag;

	// Partial remainder and shifted divisor
	logic [47:0] rem;
	logic [47:0] dsh;
	logic [15:0] q;
	// Quotient does not fit 16 bits
	logic ovf;
	// Operand signs differ
	logic neg;
	logic run;
	logic [4:0] cnt;
	// Clipped magnitude
	logic [15:0] mag;

	always_comb
	begin
		num_mag = num[15] ? 48'(-acc_t'(num)) : 48'(acc_t'(num));
		den_mag = den[31] ? 48'(-acc_t'(den)) : 48'(acc_t'(den));
		mag = (ovf || q[15]) ? 16'd32767 : q;
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer, load plus 16 bit steps plus result
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			run <= 1'b0;
			cnt <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= 1'b0;
			if (div_start)
			begin
				run <= 1'b1;
				cnt <= '0;
			end
			else if (run)
			begin
				if (cnt == 5'd16)
				begin
					run <= 1'b0;
					div_done <= 1'b1;
				end
				cnt <= cnt + 5'd1;
			end
		end
	end

	// Restoring steps on magnitudes
	always_ff @(posedge clock)
	begin
		if (div_start)
		begin
			rem <= num_mag << 15;
			dsh <= den_mag << 15;
			ovf <= (num_mag << 15) >= (den_mag << 16);
			neg <= num[15] ^ den[31];
			q <= '0;
		end
		else if (run && cnt != 5'd16)
		begin
			if (rem >= dsh)
			begin
				rem <= rem - dsh;
				q <= {q[14:0], 1'b1};
			end
			else
				q <= {q[14:0], 1'b0};
			dsh <= dsh >> 1;
		end
		// k carries the opposite sign of num/den
		if (run && cnt == 5'd16)
			k <= neg ? sample_t'(mag) : -sample_t'(mag);
	end

endmodule

//--- src/ld_recursion.sv
`timescale 1ns/10ps

module ld_recursion #(
	parameter int ORDER = 10
) (
	input logic clock,
	input logic rst,
	input logic start,
	input ld_pkg::scratch_word_t rdata,
	input logic num_valid,
	input ld_pkg::sample_t num,
	input ld_pkg::energy_t energy,
	output logic busy,
	output logic done,
	output logic eng_we,
	output logic [ld_pkg::MEM_AW-1:0] eng_addr,
	output ld_pkg::scratch_word_t eng_wdata,
	output logic term_valid,
	output ld_pkg::mac_term_t term,
	output logic init,
	output logic update,
	output ld_pkg::sample_t r0,
	output ld_pkg::sample_t k
);
	import ld_pkg::*;

	localparam logic [3:0] ORD = 4'(ORDER);
	// a[0] = 1.0 in Q12
	localparam sample_t A0 = 16'sd4096;

	// State codes
	localparam logic [3:0] S_IDLE = 4'd0;
	localparam logic [3:0] S_LOAD = 4'd1;
	localparam logic [3:0] S_LOADW = 4'd2;
	localparam logic [3:0] S_INIT = 4'd3;
	localparam logic [3:0] S_MAC = 4'd4;
	localparam logic [3:0] S_NUM = 4'd5;
	localparam logic [3:0] S_DIV = 4'd6;
	localparam logic [3:0] S_KUP = 4'd7;
	localparam logic [3:0] S_UPD = 4'd8;
	localparam logic [3:0] S_WRITE = 4'd9;

	logic [3:0] state;
	// Step index and inner index
	logic [3:0] i;
	logic [3:0] j;

	// Local copies of R, a, old a and rc
	sample_t r [0:ORDER];
	sample_t a [0:ORDER];
	sample_t a_old [0:ORDER];
	sample_t rc [0:ORDER];

	// Divider hookup
	logic div_start;
	logic div_done;
	sample_t div_k;

	// Coefficient update
	acc_t upd_prod;
	sample_t a_upd;
	logic step_end;

	ld_divider u_div (
		.clock(clock),
		.rst(rst),
		.div_start(div_start),
		.num(num),
		.den(energy),
		.div_done(div_done),
		.k(div_k)
	);

	//////////////////////////////////////////////////////////////////////
	// Strobes and streams
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// MAC terms a[j] * R[i-j]
		term_valid = (state == S_MAC);
		term.first = (j == 4'd0);
		term.last = (j == i - 4'd1);
		term.coef = a[j];
		term.corr = r[i - j];
		div_start = (state == S_NUM) && num_valid;
		init = (state == S_INIT);
		update = (state == S_KUP);
		r0 = r[0];
		// Memory port
		eng_we = (state == S_WRITE);
		if (state == S_WRITE)
			eng_addr = RES_BASE + MEM_AW'(j);
		else
			eng_addr = R_BASE + MEM_AW'(j);
		eng_wdata.res.coef = a[j];
		eng_wdata.res.rc = rc[j];
		// a[j] + k*a_old[i-j], Q12
		upd_prod = (acc_t'(k) * acc_t'(a_old[i - j])) >>> 15;
		a_upd = sat16(acc_t'(a_old[j]) + upd_prod);
		// Step 1 has no inner update
		if (state == S_KUP)
			step_end = (i == 4'd1);
		else
			step_end = (j == i - 4'd1);
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			i <= '0;
			j <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_IDLE:
					if (start)
					begin
						busy <= 1'b1;
						j <= '0;
						state <= S_LOAD;
					end
				// Address out, data back next cycle
				S_LOAD:
					state <= S_LOADW;
				S_LOADW:
					if (j == ORD)
						state <= S_INIT;
					else
					begin
						j <= j + 4'd1;
						state <= S_LOAD;
					end
				S_INIT:
				begin
					i <= 4'd1;
					j <= '0;
					state <= S_MAC;
				end
				S_MAC:
					if (j == i - 4'd1)
						state <= S_NUM;
					else
						j <= j + 4'd1;
				S_NUM:
					if (num_valid)
						state <= S_DIV;
				S_DIV:
					if (div_done)
						state <= S_KUP;
				S_KUP, S_UPD:
					if (step_end)
					begin
						j <= '0;
						if (i == ORD)
							state <= S_WRITE;
						else
						begin
							i <= i + 4'd1;
							state <= S_MAC;
						end
					end
					else
					begin
						// Inner loop j = 1 .. i-1
						j <= (state == S_KUP) ? 4'd1 : j + 4'd1;
						state <= S_UPD;
					end
				S_WRITE:
					if (j == ORD)
					begin
						busy <= 1'b0;
						done <= 1'b1;
						state <= S_IDLE;
					end
					else
						j <= j + 4'd1;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Register file updates
	always_ff @(posedge clock)
	begin
		if (state == S_LOADW)
			r[j] <= rdata.r[15:0];
		if (state == S_INIT)
		begin
			a[0] <= A0;
			rc[0] <= '0;
		end
		// Latch k and freeze old coefficients
		if (state == S_DIV && div_done)
		begin
			k <= div_k;
			a_old <= a;
		end
		if (state == S_KUP)
		begin
			a[i] <= k >>> 3;
			rc[i] <= k;
		end
		if (state == S_UPD)
			a[j] <= a_upd;
	end

endmodule

//--- src/levinson_durbin_top.sv
`timescale 1ns/10ps

module levinson_durbin_top #(
	parameter int ORDER = 10
) (
	input logic clock,
	input logic rst,
	input logic start,
	input logic test_we,
	input logic [ld_pkg::MEM_AW-1:0] test_addr,
	input ld_pkg::scratch_word_t test_wdata,
	output ld_pkg::scratch_word_t test_rdata,
	output logic busy,
	output logic done
);
	import ld_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	// Engine memory port
	logic eng_we;
	logic [MEM_AW-1:0] eng_addr;
	scratch_word_t eng_wdata;

	// MAC stream and numerator
	logic term_valid;
	mac_term_t term;
	logic num_valid;
	sample_t num;

	// Error unit
	logic init;
	logic update;
	sample_t r0;
	sample_t k;
	energy_t energy;

	// Read data also feeds the engine
	ld_scratch_mem u_mem (
		.clock(clock),
		.rst(rst),
		.busy(busy),
		.test_we(test_we),
		.test_addr(test_addr),
		.test_wdata(test_wdata),
		.eng_we(eng_we),
		.eng_addr(eng_addr),
		.eng_wdata(eng_wdata),
		.rdata(test_rdata)
	);

	ld_recursion #(
		.ORDER(ORDER)
	) u_rec (
		.clock(clock),
		.rst(rst),
		.start(start),
		.rdata(test_rdata),
		.num_valid(num_valid),
		.num(num),
		.energy(energy),
		.busy(busy),
		.done(done),
		.eng_we(eng_we),
		.eng_addr(eng_addr),
		.eng_wdata(eng_wdata),
		.term_valid(term_valid),
		.term(term),
		.init(init),
		.update(update),
		.r0(r0),
		.k(k)
	);

	ld_mac u_mac (
		.clock(clock),
		.rst(rst),
		.term_valid(term_valid),
		.term(term),
		.num_valid(num_valid),
		.num(num)
	);

	ld_energy u_energy (
		.clock(clock),
		.rst(rst),
		.init(init),
		.update(update),
		.r0(r0),
		.k(k),
		.energy(energy)
	);

endmodule

//--- test/ld_ref_model.svh
`ifndef LD_REF_MODEL_SVH
`define LD_REF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Fixed-point Levinson-Durbin reference
//////////////////////////////////////////////////////////////////////

// Model input R and expected a, rc per index
sample_t model_r [0:15];
sample_t model_a [0:15];
sample_t model_rc [0:15];

// Clip to signed 16 bits
function automatic sample_t clip16(input longint v);
	if (v > 64'sd32767)
		return 16'sh7fff;
	if (v < -64'sd32768)
		return 16'sh8000;
	return sample_t'(v);
endfunction

// k = -(num<<15)/E, toward zero, kept within +-32767
function automatic sample_t refl_coef(input sample_t num, input longint e);
	longint q;
	q = -((longint'(num) * 64'sd32768) / e);
	if (q > 64'sd32767)
		q = 64'sd32767;
	if (q < -64'sd32767)
		q = -64'sd32767;
	return sample_t'(q);
endfunction

// Error shrinks by the squared gain, floor of 1
function automatic longint next_error(input sample_t k, input longint e);
	longint k_sq;
	longint e_new;
	k_sq = (longint'(k) * longint'(k)) >>> 15;
	e_new = e - ((k_sq * e) >>> 15);
	if (e_new < 64'sd1)
		e_new = 64'sd1;
	return e_new;
endfunction

// Full recursion over model_r[0..order]
task automatic run_model(input int order);
	sample_t a_old [0:15];
	longint e;
	longint acc;
	sample_t k;
	int i;
	int j;
	for (j = 0; j < 16; j++)
	begin
		model_a[j] = '0;
		model_rc[j] = '0;
	end
	// a[0] is 1.0 in Q12
	model_a[0] = 16'sd4096;
	e = (model_r[0] < 1) ? 64'sd1 : longint'(model_r[0]);
	for (i = 1; i <= order; i++)
	begin
		acc = 0;
		for (j = 0; j < i; j++)
			acc += longint'(model_a[j]) * longint'(model_r[i - j]);
		k = refl_coef(clip16(acc >>> 12), e);
		a_old = model_a;
		for (j = 1; j < i; j++)
			model_a[j] = clip16(longint'(a_old[j])
				+ ((longint'(k) * longint'(a_old[i - j])) >>> 15));
		// Q15 to Q12
		model_a[i] = k >>> 3;
		model_rc[i] = k;
		e = next_error(k, e);
	end
endtask

`endif

//--- test/tb_levinson.sv
`timescale 1ns/10ps

module tb_levinson;
	import ld_pkg::*;

	`include "ld_ref_model.svh"

	localparam int ORDER = 10;
	// Done wait limit in cycles
	localparam int FRAME_TIMEOUT = 5000;

	logic clock;
	logic rst;
	logic start;
	logic test_we;
	logic [MEM_AW-1:0] test_addr;
	scratch_word_t test_wdata;
	scratch_word_t test_rdata;
	logic busy;
	logic done;

	// Random seed and counters
	integer seed;
	int test_errors;
	int total_errors;
	int tests_run;
	int tests_failed;

	levinson_durbin_top #(
		.ORDER(ORDER)
	) dut_i (
		.clock(clock),
		.rst(rst),
		.start(start),
		.test_we(test_we),
		.test_addr(test_addr),
		.test_wdata(test_wdata),
		.test_rdata(test_rdata),
		.busy(busy),
		.done(done)
	);

	// 100 ns period
	always #50 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	// a and rc values
	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			test_errors++;
		end
	endtask

	// Raw scratch words
	task automatic check_word(input string name, input scratch_word_t exp,
		input scratch_word_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	// One line per finished test
	task automatic report_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("%s: ok", name);
		else
		begin
			$display("%s: %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Access port and frame control
	//////////////////////////////////////////////////////////////////////

	// Write lands on the next rising edge
	task automatic mem_write(input logic [MEM_AW-1:0] addr, input scratch_word_t word);
		@(negedge clock);
		test_we = 1'b1;
		test_addr = addr;
		test_wdata = word;
		@(negedge clock);
		test_we = 1'b0;
	endtask

	// One cycle read latency
	task automatic mem_read(input logic [MEM_AW-1:0] addr, output scratch_word_t word);
		@(negedge clock);
		test_addr = addr;
		@(negedge clock);
		word = test_rdata;
	endtask

	// R[0..ORDER] into the input area with sign extension
	task automatic load_frame;
		scratch_word_t w;
		int m;
		for (m = 0; m <= ORDER; m++)
		begin
			w.r = model_r[m];
			mem_write(R_BASE + MEM_AW'(m), w);
		end
	endtask

	// Start pulse and wait for done with an optional test write while busy
	task automatic run_frame(input bit poke, output bit finished);
		scratch_word_t junk;
		int cycles;
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (poke)
		begin
			if (busy !== 1'b1)
			begin
				$display("busy did not rise after start");
				test_errors++;
			end
			// Should be dropped by the arbiter
			junk.r = 32'sh0000_4321;
			test_we = 1'b1;
			test_addr = R_BASE + MEM_AW'(1);
			test_wdata = junk;
			@(negedge clock);
			test_we = 1'b0;
		end
		cycles = 0;
		while (done !== 1'b1 && cycles < FRAME_TIMEOUT)
		begin
			@(negedge clock);
			cycles++;
		end
		finished = (done === 1'b1);
		if (!finished)
		begin
			$display("Frame did not finish within %0d cycles", FRAME_TIMEOUT);
			test_errors++;
		end
	endtask

	// Model run and every result word checked against it
	task automatic compare_results(input string name);
		scratch_word_t w;
		int i;
		run_model(ORDER);
		for (i = 0; i <= ORDER; i++)
		begin
			mem_read(RES_BASE + MEM_AW'(i), w);
			check_sample(name, model_a[i], w.res.coef);
			check_sample(name, model_rc[i], w.res.rc);
		end
	endtask

	// Slowly decaying autocorrelation
	task automatic fill_decaying;
		int tbl [0:15];
		int m;
		tbl = '{32767, 29000, 24000, 18500, 13000, 8200, 4500, 1800,
			200, -700, -1100, -1200, -1000, -700, -400, -200};
		for (m = 0; m < 16; m++)
			model_r[m] = sample_t'(tbl[m]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	// Right after reset release and before any read
	task automatic after_reset;
		if (busy !== 1'b0)
		begin
			$display("busy is not low after reset");
			test_errors++;
		end
		if (done !== 1'b0)
		begin
			$display("done is not low after reset");
			test_errors++;
		end
		check_word("after reset", '0, test_rdata);
		report_test("after reset");
	endtask

	// Both union views through the test port
	task automatic port_round_trip;
		scratch_word_t w;
		scratch_word_t exp;
		scratch_word_t got;
		logic signed [31:0] v;
		sample_t c;
		sample_t rc;
		int n;
		for (n = 0; n < 4; n++)
		begin
			// Input view in and result view out
			v = $random(seed);
			w.r = v;
			mem_write(5'd28 + MEM_AW'(n), w);
			mem_read(5'd28 + MEM_AW'(n), got);
			check_word("port round trip", w, got);
			check_sample("port round trip", sample_t'(v[31:16]), got.res.coef);
			check_sample("port round trip", sample_t'(v[15:0]), got.res.rc);
			// Result view in and input view out
			c = $random(seed);
			rc = $random(seed);
			w.res.coef = c;
			w.res.rc = rc;
			mem_write(5'd28 + MEM_AW'(n), w);
			mem_read(5'd28 + MEM_AW'(n), got);
			exp.r = {c, rc};
			check_word("port round trip", exp, got);
		end
		report_test("port round trip");
	endtask

	task automatic decaying_frame;
		scratch_word_t w;
		bit finished;
		fill_decaying();
		load_frame();
		run_frame(1'b0, finished);
		if (finished)
		begin
			compare_results("decaying frame");
			// Word 0 is fixed
			mem_read(RES_BASE, w);
			check_sample("decaying frame", 16'sd4096, w.res.coef);
			check_sample("decaying frame", 16'sd0, w.res.rc);
		end
		report_test("decaying frame");
	endtask

	// R from 40 random samples with R[0] scaled to 32000
	task automatic random_frames;
		int x [0:39];
		longint raw [0:15];
		bit finished;
		int f;
		int n;
		int m;
		for (f = 0; f < 20; f++)
		begin
			for (n = 0; n < 40; n++)
				x[n] = $random(seed) % 1000;
			for (m = 0; m <= ORDER; m++)
			begin
				raw[m] = 0;
				for (n = 0; n + m < 40; n++)
					raw[m] += longint'(x[n]) * longint'(x[n + m]);
			end
			for (m = 0; m <= ORDER; m++)
				model_r[m] = (raw[0] > 0) ? sample_t'((raw[m] * 32000) / raw[0]) : '0;
			load_frame();
			run_frame(1'b0, finished);
			if (finished)
				compare_results($sformatf("random frame %0d", f));
		end
		report_test("random frames");
	endtask

	// R[1] = R[0] drives k to the negative limit
	task automatic saturated_step;
		int tbl [0:15];
		scratch_word_t w;
		bit finished;
		int m;
		tbl = '{32767, 32767, 30000, 26000, 21000, 15000, 9000, 4000,
			0, -2500, -4000, -4500, -4000, -3000, -1800, -800};
		for (m = 0; m < 16; m++)
			model_r[m] = sample_t'(tbl[m]);
		load_frame();
		run_frame(1'b0, finished);
		if (finished)
		begin
			mem_read(RES_BASE + MEM_AW'(1), w);
			check_sample("saturated step", -16'sd32767, w.res.rc);
			compare_results("saturated step");
		end
		report_test("saturated step");
	endtask

	// Test port write during a run must not reach R
	task automatic write_while_busy;
		scratch_word_t w;
		scratch_word_t exp;
		bit finished;
		int i;
		fill_decaying();
		load_frame();
		run_frame(1'b0, finished);
		if (finished)
			compare_results("write while busy");
		// Cleared result area has to be rewritten by the second run
		w = '0;
		for (i = 0; i <= ORDER; i++)
			mem_write(RES_BASE + MEM_AW'(i), w);
		run_frame(1'b1, finished);
		if (finished)
		begin
			mem_read(R_BASE + MEM_AW'(1), w);
			exp.r = model_r[1];
			check_word("write while busy", exp, w);
			compare_results("write while busy");
		end
		report_test("write while busy");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed = 26149;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		clock = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		test_we = 1'b0;
		test_addr = '0;
		test_wdata = '0;
		// Three rising edges in reset
		repeat (3) @(negedge clock);
		rst = 1'b0;
		after_reset();
		port_round_trip();
		decaying_frame();
		random_frames();
		saturated_step();
		write_while_busy();
		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+test
src/ld_pkg.sv
src/ld_scratch_mem.sv
src/ld_mac.sv
src/ld_energy.sv
src/ld_divider.sv
src/ld_recursion.sv
src/levinson_durbin_top.sv
test/tb_levinson.sv
